// ==== vector_alu.f ====
logic/valu_types_pkg.sv
logic/valu_op_pkg.sv
logic/valu_decode.sv
logic/valu_arith_unit.sv
logic/valu_bitwise_unit.sv
logic/valu_reduce_unit.sv
logic/valu_resp_merge.sv
logic/vector_alu.sv
testbench/tb_vector_alu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vector_alu.f --top-module tb_vector_alu \
    -o tb_vector_alu || exit 1
out=$(./obj_dir/tb_vector_alu)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF "All checks passed" && exit 0 || exit 1

// ==== testbench/tb_vector_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vector_alu import valu_types_pkg::*; import valu_op_pkg::*; ();

    localparam int ADDR_W  = 32;
    localparam int N_IDLE  = 10;
    localparam int N_ARITH = 300;
    localparam int N_BIT   = 200;
    localparam int N_RED   = 60;
    localparam int N_MIX   = 60;
    localparam int N_BAD   = 80;
    // Worst case cycles per phase
    // Mixed groups take up to 4 beats plus 3 extra beats after each
    localparam int CYCLE_LIMIT = 5 + 2 * N_IDLE + N_ARITH + N_BIT + 4 * N_RED
                                 + 16 * N_MIX + N_BAD + 100;

    localparam logic [2:0] PH_IDLE  = 3'd0;
    localparam logic [2:0] PH_ARITH = 3'd1;
    localparam logic [2:0] PH_BIT   = 3'd2;
    localparam logic [2:0] PH_RED   = 3'd3;
    localparam logic [2:0] PH_MIX   = 3'd4;
    localparam logic [2:0] PH_BAD   = 3'd5;

    typedef struct packed {
        logic              valid;
        logic [2:0]        mnr;
        logic [5:0]        func;
        sew_e              sew;
        vword_t            d0;
        vword_t            d1;
        bemask_t           be;
        logic [ADDR_W-1:0] addr;
        logic              start;
        logic              last;
    } beat_t;

    typedef struct packed {
        logic [31:0]       due;     // Cycle the response is sampled
        logic [2:0]        phase;
        vword_t            data;
        logic [ADDR_W-1:0] addr;
        logic              start;
        logic              last;
    } exp_t;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic [2:0]        req_op_mnr;
    logic [5:0]        req_func_id;
    sew_e              req_sew;
    vword_t            req_data0;
    vword_t            req_data1;
    bemask_t           req_be;
    logic [ADDR_W-1:0] req_addr;
    logic              req_start;
    logic              req_end;
    logic              resp_valid;
    vword_t            resp_data;
    logic [ADDR_W-1:0] resp_addr;
    logic              resp_start;
    logic              resp_end;

    exp_t        exp_q[$];
    int          cycle = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    logic [2:0]  cur_phase = PH_IDLE;
    logic [31:0] lfsr = 32'h94ee;

    vector_alu #(.DATA_W(64), .ADDR_W(ADDR_W)) vector_alu_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_be      (req_be),
        .req_addr    (req_addr),
        .req_start   (req_start),
        .req_end     (req_end),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic vword_t lane_mask(input sew_e sew);
        return (sew == SEW64) ? {64{1'b1}} : ((64'd1 << (8 << sew)) - 64'd1);
    endfunction

    function automatic logic signed [63:0] to_signed(input vword_t v, input sew_e sew);
        vword_t m;
        m = lane_mask(sew);
        if ((v & (m ^ (m >> 1))) != '0) begin
            return $signed(v | ~m);
        end
        return $signed(v & m);
    endfunction

    function automatic vword_t elem_model(input logic [5:0] func, input sew_e sew,
                                          input vword_t a, input vword_t b, input bemask_t be);
        int     w;
        vword_t m;
        vword_t x;
        vword_t y;
        vword_t r;
        vword_t res;
        w   = 8 << sew;
        m   = lane_mask(sew);
        res = '0;
        for (int i = 0; i < 64 / w; i++) begin
            x = (a >> (i * w)) & m;
            y = (b >> (i * w)) & m;
            case (func)
                FUNC_ADD:  r = x + y;
                FUNC_SUB:  r = x - y;
                FUNC_MINU: r = (x < y) ? x : y;
                FUNC_MAXU: r = (x < y) ? y : x;
                FUNC_MIN:  r = (to_signed(x, sew) < to_signed(y, sew)) ? x : y;
                FUNC_MAX:  r = (to_signed(x, sew) < to_signed(y, sew)) ? y : x;
                FUNC_AND:  r = x & y;
                FUNC_OR:   r = x | y;
                FUNC_XOR:  r = x ^ y;
                default:   r = '0;
            endcase
            res = res | ((r & m) << (i * w));
        end
        if (func == FUNC_MERGE) begin
            for (int j = 0; j < 8; j++) begin
                res[j*8 +: 8] = be[j] ? a[j*8 +: 8] : b[j*8 +: 8];   // be set picks data0
            end
        end
        return res;
    endfunction

    function automatic logic signed [63:0] red_fold(input logic signed [63:0] acc,
                                                   input logic [5:0] func, input sew_e sew,
                                                   input vword_t data);
        int                 w;
        logic signed [63:0] e;
        logic signed [63:0] r;
        w = 8 << sew;
        r = acc;
        for (int i = 0; i < 64 / w; i++) begin
            e = to_signed(data >> (i * w), sew);
            case (func)
                FUNC_REDMIN: r = (e < r) ? e : r;
                FUNC_REDMAX: r = (e > r) ? e : r;
                default:     r = r + e;   // Wraps once masked to SEW
            endcase
        end
        return r;
    endfunction

    function automatic bit is_known(input logic [2:0] mnr, input logic [5:0] func);
        if (mnr == OPMNR_RED) begin
            return func inside {FUNC_REDSUM, FUNC_REDMIN, FUNC_REDMAX};
        end
        return func inside {FUNC_ADD, FUNC_SUB, FUNC_MINU, FUNC_MIN, FUNC_MAXU, FUNC_MAX,
                            FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_MERGE};
    endfunction

    function automatic string test_name(input logic [2:0] phase);
        case (phase)
            PH_IDLE:  return "idle";
            PH_ARITH: return "arith";
            PH_BIT:   return "bitwise";
            PH_RED:   return "reduce";
            PH_MIX:   return "interleave";
            default:  return "no_response";
        endcase
    endfunction

    function automatic beat_t rand_payload();
        beat_t bt;
        bt.valid = 1'b1;
        bt.mnr   = 3'd0;
        bt.func  = 6'd0;
        bt.sew   = sew_e'(2'(rand_bits(2)));
        bt.d0    = rand_bits(64);
        bt.d1    = rand_bits(64);
        bt.be    = 8'(rand_bits(8));
        bt.addr  = ADDR_W'(rand_bits(ADDR_W));
        bt.start = 1'(rand_bits(1));
        bt.last  = 1'(rand_bits(1));
        return bt;
    endfunction

    task automatic check(input string test, input string field,
                         input logic [63:0] expected, input logic [63:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic apply_beat(input beat_t bt);
        req_valid   <= bt.valid;
        req_op_mnr  <= bt.mnr;
        req_func_id <= bt.func;
        req_sew     <= bt.sew;
        req_data0   <= bt.d0;
        req_data1   <= bt.d1;
        req_be      <= bt.be;
        req_addr    <= bt.addr;
        req_start   <= bt.start;
        req_end     <= bt.last;
    endtask

    task automatic drive_beat(input beat_t bt);
        @(posedge clk);
        apply_beat(bt);
    endtask

    // One edge for the DUT to sample plus three register stages
    task automatic expect_resp(input logic [2:0] phase, input vword_t data,
                               input logic [ADDR_W-1:0] addr, input logic start,
                               input logic last);
        exp_t e;
        e.due   = 32'(cycle + 4);
        e.phase = phase;
        e.data  = data;
        e.addr  = addr;
        e.start = start;
        e.last  = last;
        exp_q.push_back(e);
    endtask

    task automatic send_idle();
        drive_beat('0);
    endtask

    task automatic send_elem(input logic [2:0] phase, input bit bitwise);
        beat_t      bt;
        logic [2:0] pick;
        bt   = rand_payload();
        pick = 3'(rand_bits(3));
        if (bitwise) begin
            case (pick[1:0])
                2'd0:    bt.func = FUNC_AND;
                2'd1:    bt.func = FUNC_OR;
                2'd2:    bt.func = FUNC_XOR;
                default: bt.func = FUNC_MERGE;
            endcase
        end else begin
            case (pick)
                3'd0, 3'd6: bt.func = FUNC_ADD;
                3'd1, 3'd7: bt.func = FUNC_SUB;
                3'd2:       bt.func = FUNC_MINU;
                3'd3:       bt.func = FUNC_MIN;
                3'd4:       bt.func = FUNC_MAXU;
                default:    bt.func = FUNC_MAX;
            endcase
        end
        bt.mnr = 3'(rand_bits(3));
        if (bt.mnr == OPMNR_RED) begin
            bt.mnr = 3'd0;
        end
        drive_beat(bt);
        expect_resp(phase, elem_model(bt.func, bt.sew, bt.d0, bt.d1, bt.be), bt.addr,
                    bt.start, bt.last);
    endtask

    task automatic send_group(input logic [2:0] phase, input bit mix);
        beat_t              bt;
        logic [1:0]         pick;
        logic [5:0]         func;
        sew_e               sew;
        int                 beats;
        int                 gap;
        logic signed [63:0] acc;
        pick  = 2'(rand_bits(2));
        func  = (pick == 2'd1) ? FUNC_REDMIN : (pick == 2'd2) ? FUNC_REDMAX : FUNC_REDSUM;
        sew   = sew_e'(2'(rand_bits(2)));
        beats = 1 + int'(rand_bits(2));
        acc   = '0;
        for (int k = 0; k < beats; k++) begin
            bt       = rand_payload();
            bt.mnr   = OPMNR_RED;
            bt.func  = func;
            bt.sew   = sew;
            bt.start = (k == 0);
            bt.last  = (k == beats - 1);
            if (bt.start) begin
                acc = to_signed(bt.d1, sew);   // Seed from element 0 of data1
            end
            acc = red_fold(acc, func, sew, bt.d0);
            drive_beat(bt);
            if (bt.last) begin
                expect_resp(phase, vword_t'(acc) & lane_mask(sew), bt.addr, 1'b1, 1'b1);
            end else if (mix) begin
                gap = int'(rand_bits(2));
                for (int g = 0; g < gap; g++) begin
                    if (rand_bits(1) == 64'd1) begin
                        send_elem(phase, 1'(rand_bits(1)));
                    end else begin
                        send_idle();
                    end
                end
            end
        end
    endtask

    task automatic send_bad();
        beat_t bt;
        bt      = rand_payload();
        bt.mnr  = 3'(rand_bits(3));
        bt.func = 6'(rand_bits(6));
        if (rand_bits(1) == 64'd1) begin
            bt.valid = 1'b0;   // Live fields on an idle bus
        end else if (is_known(bt.mnr, bt.func)) begin
            bt.func = 6'd63;
        end
        drive_beat(bt);
    endtask

    always @(posedge clk) begin : monitor
        exp_t got;
        cycle <= cycle + 1;
        if (!rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                got = exp_q.pop_front();
                check(test_name(got.phase), "resp_valid", 64'd1, 64'(resp_valid));
                check(test_name(got.phase), "resp_data", got.data, resp_data);
                check(test_name(got.phase), "resp_addr", 64'(got.addr), 64'(resp_addr));
                check(test_name(got.phase), "resp_start", 64'(got.start), 64'(resp_start));
                check(test_name(got.phase), "resp_end", 64'(got.last), 64'(resp_end));
            end else begin
                check(test_name(cur_phase), "resp_valid", 64'd0, 64'(resp_valid));
            end
        end
    end

    initial begin : watchdog
        wait (cycle >= CYCLE_LIMIT);
        $display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        rst <= 1'b1;
        apply_beat('0);
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < N_IDLE; i++) send_idle();
        cur_phase <= PH_ARITH;
        for (int i = 0; i < N_ARITH; i++) send_elem(PH_ARITH, 1'b0);
        cur_phase <= PH_BIT;
        for (int i = 0; i < N_BIT; i++) send_elem(PH_BIT, 1'b1);
        cur_phase <= PH_RED;
        for (int i = 0; i < N_RED; i++) send_group(PH_RED, 1'b0);
        cur_phase <= PH_MIX;
        for (int i = 0; i < N_MIX; i++) send_group(PH_MIX, 1'b1);
        cur_phase <= PH_BAD;
        for (int i = 0; i < N_BAD; i++) send_bad();
        for (int i = 0; i < N_IDLE; i++) send_idle();

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) send_idle();
        @(negedge clk);

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/vector_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_alu import valu_types_pkg::*; import valu_op_pkg::*; #(
    parameter int DATA_W = valu_types_pkg::DATA_W,
    parameter int ADDR_W = valu_types_pkg::ADDR_W
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              req_valid,
    input  wire [2:0]        req_op_mnr,
    input  wire [5:0]        req_func_id,
    input  wire sew_e        req_sew,
    input  wire vword_t      req_data0,
    input  wire vword_t      req_data1,
    input  wire bemask_t     req_be,
    input  wire [ADDR_W-1:0] req_addr,
    input  wire              req_start,
    input  wire              req_end,
    output wire              resp_valid,
    output wire vword_t      resp_data,
    output wire [ADDR_W-1:0] resp_addr,
    output wire              resp_start,
    output wire              resp_end
);

    dec_op_t           dec_op;
    vword_t            op_data0;
    vword_t            op_data1;
    bemask_t           op_be;
    logic [ADDR_W-1:0] op_addr;

    logic              arith_valid;
    vword_t            arith_data;
    logic [ADDR_W-1:0] arith_addr;
    logic              arith_start;
    logic              arith_end;
    logic              bit_valid;
    vword_t            bit_data;
    logic [ADDR_W-1:0] bit_addr;
    logic              bit_start;
    logic              bit_end;
    logic              red_valid;
    vword_t            red_data;
    logic [ADDR_W-1:0] red_addr;

    valu_decode #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) valu_decode_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op_mnr  (req_op_mnr),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_be      (req_be),
        .req_addr    (req_addr),
        .req_start   (req_start),
        .req_end     (req_end),
        .dec_op      (dec_op),
        .op_data0    (op_data0),
        .op_data1    (op_data1),
        .op_be       (op_be),
        .op_addr     (op_addr)
    );

    valu_arith_unit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) valu_arith_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .dec_op      (dec_op),
        .op_data0    (op_data0),
        .op_data1    (op_data1),
        .op_addr     (op_addr),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .arith_addr  (arith_addr),
        .arith_start (arith_start),
        .arith_end   (arith_end)
    );

    valu_bitwise_unit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) valu_bitwise_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .dec_op    (dec_op),
        .op_data0  (op_data0),
        .op_data1  (op_data1),
        .op_be     (op_be),
        .op_addr   (op_addr),
        .bit_valid (bit_valid),
        .bit_data  (bit_data),
        .bit_addr  (bit_addr),
        .bit_start (bit_start),
        .bit_end   (bit_end)
    );

    valu_reduce_unit #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) valu_reduce_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .dec_op    (dec_op),
        .op_data0  (op_data0),
        .op_data1  (op_data1),
        .op_addr   (op_addr),
        .red_valid (red_valid),
        .red_data  (red_data),
        .red_addr  (red_addr)
    );

    valu_resp_merge #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) valu_resp_merge_inst (
        .clk         (clk),
        .rst         (rst),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .arith_addr  (arith_addr),
        .arith_start (arith_start),
        .arith_end   (arith_end),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .bit_addr    (bit_addr),
        .bit_start   (bit_start),
        .bit_end     (bit_end),
        .red_valid   (red_valid),
        .red_data    (red_data),
        .red_addr    (red_addr),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

endmodule

`default_nettype wire

// ==== logic/valu_resp_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_resp_merge import valu_types_pkg::*; #(
    parameter int DATA_W = valu_types_pkg::DATA_W,
    parameter int ADDR_W = valu_types_pkg::ADDR_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               arith_valid,
    input  wire vword_t       arith_data,
    input  wire [ADDR_W-1:0]  arith_addr,
    input  wire               arith_start,
    input  wire               arith_end,
    input  wire               bit_valid,
    input  wire vword_t       bit_data,
    input  wire [ADDR_W-1:0]  bit_addr,
    input  wire               bit_start,
    input  wire               bit_end,
    input  wire               red_valid,
    input  wire vword_t       red_data,
    input  wire [ADDR_W-1:0]  red_addr,
    output logic              resp_valid,
    output vword_t            resp_data,
    output logic [ADDR_W-1:0] resp_addr,
    output logic              resp_start,
    output logic              resp_end
);

    if (DATA_W != $bits(vword_t)) begin : g_width_check
        $error("DATA_W does not match vword_t");
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            resp_valid <= arith_valid | bit_valid | red_valid;
            resp_start <= arith_start | bit_start | red_valid;  // Reduction is a whole group
            resp_end   <= arith_end | bit_end | red_valid;
        end
    end

    // Idle units drive zero
    always_ff @(posedge clk) begin
        resp_data <= arith_data | bit_data | red_data;
        resp_addr <= arith_addr | bit_addr | red_addr;
    end

    a_one_source: assert property (@(posedge clk) disable iff (rst)
        $onehot0({arith_valid, bit_valid, red_valid}));

endmodule

`default_nettype wire

// ==== logic/valu_reduce_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_reduce_unit import valu_types_pkg::*; import valu_op_pkg::*; #(
    parameter int DATA_W = valu_types_pkg::DATA_W,
    parameter int ADDR_W = valu_types_pkg::ADDR_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire dec_op_t      dec_op,
    input  wire vword_t       op_data0,
    input  wire vword_t       op_data1,
    input  wire [ADDR_W-1:0]  op_addr,
    output logic              red_valid,
    output vword_t            red_data,
    output logic [ADDR_W-1:0] red_addr
);

    logic   active;      // Inside a register group
    vword_t acc;         // Sign-extended running value
    vword_t seed;
    vword_t acc_next;
    vword_t elem_mask;
    logic   is_red;
    logic   red_fire;

    // Low w bits of v, sign-extended to the full word
    function automatic logic signed [DATA_W-1:0] sext(input vword_t v, input int unsigned w);
        logic signed [DATA_W-1:0] t;
        t = $signed(v);
        return (t <<< (DATA_W - w)) >>> (DATA_W - w);
    endfunction

    function automatic vword_t fold(input vword_t start_val, input vword_t data,
                                    input sew_e sew, input op_e op);
        int unsigned w;
        logic signed [DATA_W-1:0] a;
        logic signed [DATA_W-1:0] e;
        w = 8 << sew;
        a = $signed(start_val);
        for (int i = 0; i < DATA_W / 8; i++) begin
            if (i * w < DATA_W) begin
                e = sext(data >> (i * w), w);
                case (op)
                    OP_REDMIN: a = (e < a) ? e : a;
                    OP_REDMAX: a = (e > a) ? e : a;
                    default:   a = a + e;
                endcase
            end
        end
        return sext(a, w);   // Sum wraps at SEW
    endfunction

    assign is_red    = dec_op.valid && (dec_op.op inside {OP_REDSUM, OP_REDMIN, OP_REDMAX});
    assign red_fire  = is_red & dec_op.last;
    assign seed      = dec_op.start ? sext(op_data1, 8 << dec_op.sew) : acc;
    assign acc_next  = fold(seed, op_data0, dec_op.sew, dec_op.op);
    assign elem_mask = ~({DATA_W{1'b1}} << (8 << dec_op.sew));

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            acc       <= '0;
            red_valid <= 1'b0;
        end else begin
            red_valid <= red_fire;
            if (red_fire) begin
                active <= 1'b0;
                acc    <= '0;
            end else if (is_red) begin
                active <= 1'b1;
                acc    <= acc_next;
            end
        end
    end

    // Result in element 0 only
    always_ff @(posedge clk) begin
        red_data <= red_fire ? (acc_next & elem_mask) : '0;
        red_addr <= red_fire ? op_addr : '0;
    end

    // A group has to open with its start beat
    a_start_first: assert property (@(posedge clk) disable iff (rst)
        (is_red && !active) |-> dec_op.start);

endmodule

`default_nettype wire

// ==== logic/valu_bitwise_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_bitwise_unit import valu_types_pkg::*; import valu_op_pkg::*; #(
    parameter int DATA_W = valu_types_pkg::DATA_W,
    parameter int ADDR_W = valu_types_pkg::ADDR_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire dec_op_t      dec_op,
    input  wire vword_t       op_data0,
    input  wire vword_t       op_data1,
    input  wire bemask_t      op_be,
    input  wire [ADDR_W-1:0]  op_addr,
    output logic              bit_valid,
    output vword_t            bit_data,
    output logic [ADDR_W-1:0] bit_addr,
    output logic              bit_start,
    output logic              bit_end
);

    vword_t merged;
    vword_t res;
    logic   is_bit;

    assign is_bit = dec_op.valid && (dec_op.op inside {OP_AND, OP_OR, OP_XOR, OP_MERGE});

    always_comb begin
        for (int i = 0; i < DATA_W / 8; i++) begin
            merged[i*8 +: 8] = op_be[i] ? op_data0[i*8 +: 8] : op_data1[i*8 +: 8];
        end
        case (dec_op.op)
            OP_AND:   res = op_data0 & op_data1;
            OP_OR:    res = op_data0 | op_data1;
            OP_XOR:   res = op_data0 ^ op_data1;
            OP_MERGE: res = merged;
            default:  res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_valid <= 1'b0;
            bit_start <= 1'b0;
            bit_end   <= 1'b0;
        end else begin
            bit_valid <= is_bit;
            bit_start <= is_bit & dec_op.start;
            bit_end   <= is_bit & dec_op.last;
        end
    end

    always_ff @(posedge clk) begin
        bit_data <= is_bit ? res : '0;
        bit_addr <= is_bit ? op_addr : '0;
    end

endmodule

`default_nettype wire

// ==== logic/valu_arith_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_arith_unit import valu_types_pkg::*; import valu_op_pkg::*; #(
    parameter int DATA_W = valu_types_pkg::DATA_W,
    parameter int ADDR_W = valu_types_pkg::ADDR_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire dec_op_t      dec_op,
    input  wire vword_t       op_data0,
    input  wire vword_t       op_data1,
    input  wire [ADDR_W-1:0]  op_addr,
    output logic              arith_valid,
    output vword_t            arith_data,
    output logic [ADDR_W-1:0] arith_addr,
    output logic              arith_start,
    output logic              arith_end
);

    vword_t res_sew [4];   // One candidate result per element width
    vword_t res;
    logic   is_arith;

    assign is_arith = dec_op.valid &&
        (dec_op.op inside {OP_ADD, OP_SUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX});

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        localparam int N = DATA_W / W;

        for (genvar l = 0; l < N; l++) begin : g_lane
            logic [W-1:0] a;
            logic [W-1:0] b;
            logic [W-1:0] r;
            logic         lt_u;
            logic         lt_s;

            assign a    = op_data0[l*W +: W];
            assign b    = op_data1[l*W +: W];
            assign lt_u = a < b;
            assign lt_s = $signed(a) < $signed(b);

            always_comb begin
                case (dec_op.op)
                    OP_ADD:  r = a + b;   // Wraps at lane width
                    OP_SUB:  r = a - b;
                    OP_MINU: r = lt_u ? a : b;
                    OP_MIN:  r = lt_s ? a : b;
                    OP_MAXU: r = lt_u ? b : a;
                    OP_MAX:  r = lt_s ? b : a;
                    default: r = '0;
                endcase
            end

            assign res_sew[s][l*W +: W] = r;
        end
    end

    assign res = res_sew[dec_op.sew];

    always_ff @(posedge clk) begin
        if (rst) begin
            arith_valid <= 1'b0;
            arith_start <= 1'b0;
            arith_end   <= 1'b0;
        end else begin
            arith_valid <= is_arith;
            arith_start <= is_arith & dec_op.start;
            arith_end   <= is_arith & dec_op.last;
        end
    end

    // Zero when idle so the response stage can OR
    always_ff @(posedge clk) begin
        arith_data <= is_arith ? res : '0;
        arith_addr <= is_arith ? op_addr : '0;
    end

    a_idle_zero: assert property (@(posedge clk) disable iff (rst)
        !arith_valid |-> (arith_data == '0 && arith_addr == '0));

endmodule

`default_nettype wire

// ==== logic/valu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_decode import valu_types_pkg::*; import valu_op_pkg::*; #(
    parameter int DATA_W = valu_types_pkg::DATA_W,
    parameter int ADDR_W = valu_types_pkg::ADDR_W
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               req_valid,
    input  wire [2:0]         req_op_mnr,
    input  wire [5:0]         req_func_id,
    input  wire sew_e         req_sew,
    input  wire vword_t       req_data0,
    input  wire vword_t       req_data1,
    input  wire bemask_t      req_be,
    input  wire [ADDR_W-1:0]  req_addr,
    input  wire               req_start,
    input  wire               req_end,
    output dec_op_t           dec_op,
    output vword_t            op_data0,
    output vword_t            op_data1,
    output bemask_t           op_be,
    output logic [ADDR_W-1:0] op_addr
);

    op_e  op_next;
    logic known;

    if (DATA_W != $bits(vword_t)) begin : g_width_check
        $error("DATA_W does not match vword_t");
    end

    always_comb begin
        op_next = OP_ADD;
        known   = 1'b1;
        if (req_op_mnr == OPMNR_RED) begin
            case (req_func_id)
                FUNC_REDSUM: op_next = OP_REDSUM;
                FUNC_REDMIN: op_next = OP_REDMIN;
                FUNC_REDMAX: op_next = OP_REDMAX;
                default:     known   = 1'b0;
            endcase
        end else begin
            case (req_func_id)
                FUNC_ADD:   op_next = OP_ADD;
                FUNC_SUB:   op_next = OP_SUB;
                FUNC_MINU:  op_next = OP_MINU;
                FUNC_MIN:   op_next = OP_MIN;
                FUNC_MAXU:  op_next = OP_MAXU;
                FUNC_MAX:   op_next = OP_MAX;
                FUNC_AND:   op_next = OP_AND;
                FUNC_OR:    op_next = OP_OR;
                FUNC_XOR:   op_next = OP_XOR;
                FUNC_MERGE: op_next = OP_MERGE;
                default:    known   = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_op <= '0;
        end else begin
            dec_op <= '{valid: req_valid & known, op: op_next, sew: req_sew,
                        start: req_valid & req_start, last: req_valid & req_end};
        end
    end

    always_ff @(posedge clk) begin
        op_data0 <= req_data0;
        op_data1 <= req_data1;
        op_be    <= req_be;
        op_addr  <= req_addr;
    end

    // Nothing is decoded out of an idle request bus
    a_valid_from_req: assert property (@(posedge clk) disable iff (rst)
        dec_op.valid |-> $past(req_valid));

endmodule

`default_nettype wire

// ==== logic/valu_op_pkg.sv ====
`default_nettype none

package valu_op_pkg;

    import valu_types_pkg::*;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_MINU,
        OP_MIN,
        OP_MAXU,
        OP_MAX,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MERGE,
        OP_REDSUM,
        OP_REDMIN,
        OP_REDMAX
    } op_e;

    // Element-wise function codes
    localparam logic [5:0] FUNC_ADD   = 6'd0;
    localparam logic [5:0] FUNC_SUB   = 6'd2;
    localparam logic [5:0] FUNC_MINU  = 6'd4;
    localparam logic [5:0] FUNC_MIN   = 6'd5;
    localparam logic [5:0] FUNC_MAXU  = 6'd6;
    localparam logic [5:0] FUNC_MAX   = 6'd7;
    localparam logic [5:0] FUNC_AND   = 6'd9;
    localparam logic [5:0] FUNC_OR    = 6'd10;
    localparam logic [5:0] FUNC_XOR   = 6'd11;
    localparam logic [5:0] FUNC_MERGE = 6'd23;

    // Reduction codes under OPMNR_RED
    localparam logic [5:0] FUNC_REDSUM = 6'd0;
    localparam logic [5:0] FUNC_REDMIN = 6'd5;
    localparam logic [5:0] FUNC_REDMAX = 6'd7;

    localparam logic [2:0] OPMNR_RED = 3'd2;

    typedef struct packed {
        logic valid;
        op_e  op;
        sew_e sew;
        logic start;
        logic last;   // End of register group
    } dec_op_t;

endpackage

`default_nettype wire

// ==== logic/valu_types_pkg.sv ====
`default_nettype none

package valu_types_pkg;

    // Default widths that module parameters override per instance
    parameter int DATA_W = 64;
    parameter int ADDR_W = 32;
    parameter int BE_W   = DATA_W / 8;

    // Element width with lanes of 8 << sew bits
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2,
        SEW64 = 2'd3
    } sew_e;

    typedef logic [DATA_W-1:0] vword_t;   // One operand or result word
    typedef logic [BE_W-1:0]   bemask_t;  // One bit per byte

endpackage

`default_nettype wire
